// ==== rv_core.f ====
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_pc_counter.sv
hw/rv_run_ctrl.sv
hw/rv_core_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rv_core testbench with verilator, run it, look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top \
  -f rv_core.f \
  -o tb_sim

output=$(./obj_dir/tb_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// ==== verification/tb_top.sv ====
/*
  testbench top for the single-cycle rv64 core
  plays instruction memory with random legal words and runs the test sequence
*/
`timescale 1ns/10ps

module tb_top;

  localparam logic [31:0] seed         = 32'hd550_7957;
  localparam logic [31:0] nop          = 32'h0000_0013;
  localparam int          stop_timeout = 8;
  localparam int          mix_len      = 200;
  localparam int          jump_len     = 120;
  localparam int          store_len    = 150;
  localparam int          after_stop   = 20;

  logic                          clk;
  logic                          rst_n;
  logic [rv_pkg::inst_width-1:0] inst;
  logic [rv_pkg::xlen-1:0]       pc;
  logic [rv_pkg::xlen-1:0]       waddr;
  logic [rv_pkg::xlen-1:0]       wdata;
  logic [7:0]                    wmask;
  logic                          mem_wen;
  logic                          halted;
  logic                          trapped;
  int                            errors;
  int                            errors_at_start;
  int                            tests_passed;
  int                            tests_failed;

  tb_clock_gen u_clock_gen (
    .clk (clk)
  );

  rv_core_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .pc      (pc),
    .waddr   (waddr),
    .wdata   (wdata),
    .wmask   (wmask),
    .mem_wen (mem_wen),
    .halted  (halted),
    .trapped (trapped)
  );

  tb_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .pc      (pc),
    .waddr   (waddr),
    .wdata   (wdata),
    .wmask   (wmask),
    .mem_wen (mem_wen),
    .halted  (halted),
    .trapped (trapped),
    .errors  (errors)
  );

  // word assemblers, one per format
  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    rv_pkg::inst_word_t w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = rv_pkg::op;
    return w;
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    rv_pkg::inst_word_t w;
    w.i.imm_11_0 = imm;
    w.i.rs1      = rs1;
    w.i.funct3   = f3;
    w.i.rd       = rd;
    w.i.opcode   = rv_pkg::op_imm;
    return w;
  endfunction

  function automatic logic [31:0] stype(input logic [2:0] f3, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    rv_pkg::inst_word_t w;
    w.s.imm_11_5 = imm[11:5];
    w.s.rs2      = rs2;
    w.s.rs1      = rs1;
    w.s.funct3   = f3;
    w.s.imm_4_0  = imm[4:0];
    w.s.opcode   = rv_pkg::store;
    return w;
  endfunction

  function automatic logic [31:0] utype(input logic [6:0] opc, input logic [19:0] imm,
                                        input logic [4:0] rd);
    rv_pkg::inst_word_t w;
    w.u.imm_31_12 = imm;
    w.u.rd        = rd;
    w.u.opcode    = opc;
    return w;
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
    rv_pkg::inst_word_t w;
    w.j.imm_20    = off[20];
    w.j.imm_10_1  = off[10:1];
    w.j.imm_11    = off[11];
    w.j.imm_19_12 = off[19:12];
    w.j.rd        = rd;
    w.j.opcode    = rv_pkg::jal;
    return w;
  endfunction

  // random op-imm, op, lui or auipc
  function automatic logic [31:0] alu_word();
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] w;
    case ($urandom_range(0, 4))
      0:       f3 = rv_pkg::f3_add;
      1:       f3 = rv_pkg::f3_slt;
      2:       f3 = rv_pkg::f3_xor;
      3:       f3 = rv_pkg::f3_or;
      default: f3 = rv_pkg::f3_and;
    endcase
    f7 = (f3 == rv_pkg::f3_add && $urandom_range(0, 1) == 1) ? rv_pkg::f7_alt : rv_pkg::f7_base;
    case ($urandom_range(0, 3))
      0:       w = itype(12'($urandom), 5'($urandom), f3, 5'($urandom));
      1:       w = rtype(f7, 5'($urandom), 5'($urandom), f3, 5'($urandom));
      2:       w = utype(rv_pkg::lui, 20'($urandom), 5'($urandom));
      default: w = utype(rv_pkg::auipc, 20'($urandom), 5'($urandom));
    endcase
    return w;
  endfunction

  // sb, sh, sw or sd from any register at any base and offset
  function automatic logic [31:0] store_word();
    return stype(3'($urandom_range(0, 3)), 5'($urandom), 5'($urandom), 12'($urandom));
  endfunction

  function automatic logic [31:0] mixed_word();
    return ($urandom_range(0, 1) == 1) ? alu_word() : store_word();
  endfunction

  // words just outside the subset
  function automatic logic [31:0] illegal_word();
    logic [31:0] w;
    case ($urandom_range(0, 4))
      0:       w = rtype(7'h01, 5'($urandom), 5'($urandom), 3'b000, 5'($urandom));
      1:       w = itype(12'($urandom_range(0, 63)), 5'($urandom), 3'b001, 5'($urandom));
      2:       w = {25'($urandom), 7'b0000011};
      3:       w = stype(3'($urandom_range(4, 7)), 5'($urandom), 5'($urandom), 12'($urandom));
      default: w = 32'h0000_0073;
    endcase
    return w;
  endfunction

  task automatic issue(input logic [31:0] word);
    @(posedge clk);
    inst <= word;
  endtask

  // reset sampled low on 4 rising edges
  task automatic start_test();
    errors_at_start = errors;
    repeat (4) begin
      @(posedge clk);
      rst_n <= 1'b0;
      inst  <= nop;
    end
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic await_stop(input logic want_halt, output logic timed_out);
    int waited;
    waited = 0;
    @(negedge clk);
    while ((want_halt ? halted : trapped) !== 1'b1 && waited < stop_timeout) begin
      @(negedge clk);
      waited++;
    end
    timed_out = ((want_halt ? halted : trapped) !== 1'b1);
    if (timed_out) begin
      $display("timeout: core did not %s within %0d cycles",
               want_halt ? "halt" : "trap", stop_timeout);
    end
  endtask

  // last word has been checked by the time the nop goes out
  task automatic close_test(input string name, input logic timed_out);
    int found;
    issue(nop);
    found = errors - errors_at_start;
    if (found == 0 && !timed_out) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed, %0d mismatches", name, found);
    end
  endtask

  task automatic stop_test(input string name, input logic [31:0] word,
                           input logic want_halt);
    int   k;
    logic timed_out;
    start_test();
    for (k = 0; k < 10; k++) begin
      issue(alu_word());
    end
    issue(word);
    await_stop(want_halt, timed_out);
    // frozen core, pc holds and nothing stores
    for (k = 0; k < after_stop; k++) begin
      issue(mixed_word());
    end
    close_test(name, timed_out);
  endtask

  initial begin
    int          i;
    logic [20:0] off;
    logic [4:0]  link;

    rst_n           = 1'b0;
    inst            = nop;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    void'($urandom(seed));

    start_test();
    issue(nop);
    issue(nop);
    close_test("1 reset state", 1'b0);

    // every register gets a known value first
    start_test();
    for (i = 1; i < 32; i++) begin
      issue(itype(12'($urandom), 5'd0, rv_pkg::f3_add, 5'(i)));
    end
    for (i = 0; i < mix_len; i++) begin
      issue(alu_word());
    end
    for (i = 0; i < 32; i++) begin
      issue(stype(3'd3, 5'(i), 5'd0, {9'($urandom), 3'b000}));
    end
    close_test("2 alu mix and register dump", 1'b0);

    start_test();
    for (i = 0; i < jump_len; i++) begin
      if ($urandom_range(0, 2) == 0) begin
        off       = 21'($urandom);
        off[1:0]  = 2'b00;
        link      = 5'($urandom_range(1, 31));
        issue(jtype(off, link));
        // link shows up through a store
        issue(stype(3'd3, link, 5'd0, {9'($urandom), 3'b000}));
      end else begin
        issue(alu_word());
      end
    end
    close_test("3 jal and pc steps", 1'b0);

    start_test();
    for (i = 0; i < store_len; i++) begin
      issue(($urandom_range(0, 3) == 0) ? alu_word() : store_word());
    end
    close_test("4 store lanes and masks", 1'b0);

    stop_test("5 ebreak halts", rv_pkg::ebreak_word, 1'b1);

    // offset with bit 1 set
    off      = 21'($urandom);
    off[1:0] = 2'b10;
    stop_test("6a misaligned jal traps", jtype(off, 5'($urandom_range(1, 31))), 1'b0);
    stop_test("6b illegal word traps", illegal_word(), 1'b0);

    $display("tests passed %0d failed %0d, mismatches %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verification/tb_checker.sv ====
/*
  reference model of the core's architectural state
  steps once per cycle on the falling edge and compares pc, store port and status
*/
`timescale 1ns/10ps

module tb_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rv_pkg::inst_width-1:0] inst,
  input  logic [rv_pkg::xlen-1:0]       pc,
  input  logic [rv_pkg::xlen-1:0]       waddr,
  input  logic [rv_pkg::xlen-1:0]       wdata,
  input  logic [7:0]                    wmask,
  input  logic                          mem_wen,
  input  logic                          halted,
  input  logic                          trapped,
  output int                            errors
);

  // first fetch after reset
  localparam logic [63:0] boot_pc = 64'h0000_0000_8000_0000;

  logic [rv_pkg::xlen-1:0] regs [32];
  logic [rv_pkg::xlen-1:0] model_pc;
  logic                    model_halted;
  logic                    model_trapped;

  initial begin
    errors        = 0;
    model_pc      = boot_pc;
    model_halted  = 1'b0;
    model_trapped = 1'b0;
    for (int n = 0; n < 32; n++) begin
      regs[n] = '0;
    end
  end

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  // integer ops as the ISA defines them, f3 picks the op
  function automatic logic [63:0] arith(input logic [2:0] f3, input logic sub,
                                        input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    case (f3)
      3'b000:  r = sub ? a - b : a + b;
      3'b010:  r = {63'd0, $signed(a) < $signed(b)};
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      3'b111:  r = a & b;
      default: r = '0;
    endcase
    return r;
  endfunction

  // outputs are settled mid-cycle, the word retires at the next rising edge
  always @(negedge clk) begin : step
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    logic [63:0] res;
    logic [63:0] addr;
    logic [63:0] next_pc;
    logic [7:0]  mask;
    logic        f3_ok;
    logic        legal;
    logic        brk;
    logic        wr;
    logic        st;

    opc   = inst[6:0];
    rd    = inst[11:7];
    f3    = inst[14:12];
    f7    = inst[31:25];
    a     = regs[inst[19:15]];
    b     = regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    // slli, sltiu and friends are outside the subset
    f3_ok = (f3 != 3'd1) && (f3 != 3'd3) && (f3 != 3'd5);

    if (!rst_n) begin
      compare("mem_wen", 64'(1'b0), 64'(mem_wen));
      model_pc      = boot_pc;
      model_halted  = 1'b0;
      model_trapped = 1'b0;
    end else begin
      compare("pc", model_pc, pc);
      compare("halted", 64'(model_halted), 64'(halted));
      compare("trapped", 64'(model_trapped), 64'(trapped));
      if (model_halted || model_trapped) begin
        // stopped: pc frozen above, no store may leave
        compare("mem_wen", 64'(1'b0), 64'(mem_wen));
      end else begin
        res     = '0;
        wr      = 1'b0;
        st      = 1'b0;
        brk     = 1'b0;
        legal   = 1'b1;
        next_pc = model_pc + 64'd4;
        case (opc)
          rv_pkg::op_imm: begin
            legal = f3_ok;
            res   = arith(f3, 1'b0, a, imm_i);
            wr    = 1'b1;
          end
          rv_pkg::op: begin
            legal = (f7 == 7'h00 && f3_ok) || (f7 == 7'h20 && f3 == 3'd0);
            res   = arith(f3, f7[5], a, b);
            wr    = 1'b1;
          end
          rv_pkg::lui: begin
            res = imm_u;
            wr  = 1'b1;
          end
          rv_pkg::auipc: begin
            res = model_pc + imm_u;
            wr  = 1'b1;
          end
          rv_pkg::jal: begin
            // target must stay word aligned
            legal   = !imm_j[1];
            res     = model_pc + 64'd4;
            next_pc = model_pc + imm_j;
            wr      = 1'b1;
          end
          rv_pkg::store: begin
            legal = !f3[2];
            st    = 1'b1;
          end
          rv_pkg::system: begin
            brk   = (inst == 32'h0010_0073);
            legal = brk;
          end
          default: legal = 1'b0;
        endcase

        if (brk) begin
          compare("mem_wen", 64'(1'b0), 64'(mem_wen));
          model_halted = 1'b1;
        end else if (!legal) begin
          compare("mem_wen", 64'(1'b0), 64'(mem_wen));
          model_trapped = 1'b1;
        end else begin
          compare("mem_wen", 64'(st), 64'(mem_wen));
          if (st) begin
            addr = a + imm_s;
            case (f3[1:0])
              2'd0:    mask = 8'h01;
              2'd1:    mask = 8'h03;
              2'd2:    mask = 8'h0f;
              default: mask = 8'hff;
            endcase
            // lanes picked by the low three address bits
            mask = mask << addr[2:0];
            compare("waddr", addr, waddr);
            compare("wdata", b << (8 * addr[2:0]), wdata);
            compare("wmask", 64'(mask), 64'(wmask));
          end
          if (wr && rd != 5'd0) begin
            regs[rd] = res;
          end
          model_pc = next_pc;
        end
      end
    end
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
  testbench clock source, 8 ns period
*/
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // half period 4 ns
  always #4 clk = ~clk;

endmodule

// ==== hw/rv_core_top.sv ====
/*
  single-cycle rv64 core top
  wires decode, registers, alu, pc and run control, and forms the store lanes
*/
`timescale 1ns/10ps

module rv_core_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rv_pkg::inst_width-1:0] inst,
  output logic [rv_pkg::xlen-1:0]       pc,
  output logic [rv_pkg::xlen-1:0]       waddr,
  output logic [rv_pkg::xlen-1:0]       wdata,
  output logic [7:0]                    wmask,
  output logic                          mem_wen,
  output logic                          halted,
  output logic                          trapped
);

  // decode outputs
  logic [rv_pkg::reg_id_width-1:0] rd;
  logic [rv_pkg::reg_id_width-1:0] rs1;
  logic [rv_pkg::reg_id_width-1:0] rs2;
  logic [rv_pkg::xlen-1:0]         imm;
  rv_pkg::alu_op_t                 alu_op;
  logic [1:0]                      store_size;
  logic                            need_imm;
  logic                            is_auipc;
  logic                            is_lui;
  logic                            is_jal;
  logic                            reg_wen_raw;
  logic                            mem_wen_raw;
  logic                            is_ebreak;
  logic                            illegal;

  // gated strobes
  logic reg_wen;
  logic pc_en;

  // datapath
  logic [rv_pkg::xlen-1:0] rdata_1;
  logic [rv_pkg::xlen-1:0] rdata_2;
  logic [rv_pkg::xlen-1:0] operand_1;
  logic [rv_pkg::xlen-1:0] operand_2;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] reg_wdata;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [7:0]              size_mask;

  rv_decoder u_decoder (
    .inst        (inst),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .imm         (imm),
    .alu_op      (alu_op),
    .store_size  (store_size),
    .need_imm    (need_imm),
    .is_auipc    (is_auipc),
    .is_lui      (is_lui),
    .is_jal      (is_jal),
    .reg_wen_raw (reg_wen_raw),
    .mem_wen_raw (mem_wen_raw),
    .is_ebreak   (is_ebreak),
    .illegal     (illegal)
  );

  rv_run_ctrl u_run_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .is_ebreak   (is_ebreak),
    .illegal     (illegal),
    .reg_wen_raw (reg_wen_raw),
    .mem_wen_raw (mem_wen_raw),
    .reg_wen     (reg_wen),
    .mem_wen     (mem_wen),
    .pc_en       (pc_en),
    .halted      (halted),
    .trapped     (trapped)
  );

  rv_pc_counter u_pc_counter (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc_en    (pc_en),
    .is_jal   (is_jal),
    .imm      (imm),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  // write-back select: link, upper immediate, or alu
  assign reg_wdata = is_jal ? pc_plus4 : (is_lui ? imm : alu_result);

  rv_regfile u_regfile (
    .clk       (clk),
    .reg_wen   (reg_wen),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .reg_wdata (reg_wdata),
    .rdata_1   (rdata_1),
    .rdata_2   (rdata_2)
  );

  // auipc adds to pc, stores and op-imm take the immediate
  assign operand_1 = is_auipc ? pc : rdata_1;
  assign operand_2 = need_imm ? imm : rdata_2;

  rv_alu u_alu (
    .operand_1  (operand_1),
    .operand_2  (operand_2),
    .alu_op     (alu_op),
    .alu_result (alu_result)
  );

  // byte, half, word, double
  always_comb begin
    case (store_size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // lanes follow the low three address bits
  assign waddr = alu_result;
  assign wdata = rdata_2 << {alu_result[2:0], 3'b000};
  assign wmask = size_mask << alu_result[2:0];

endmodule

// ==== hw/rv_run_ctrl.sv ====
/*
  run control FSM: run, halted, trapped
  stops on ebreak or an illegal word and gates every state-changing strobe
*/
`timescale 1ns/10ps

module rv_run_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic is_ebreak,
  input  logic illegal,
  input  logic reg_wen_raw,
  input  logic mem_wen_raw,
  output logic reg_wen,
  output logic mem_wen,
  output logic pc_en,
  output logic halted,
  output logic trapped
);

  logic [1:0] state;
  logic       stop;
  logic       live;

  assign stop = is_ebreak || illegal;

  // nothing retires under reset or once stopped
  assign live = rst_n && (state == rv_pkg::rc_run) && !stop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= rv_pkg::rc_run;
    end else if (state == rv_pkg::rc_run) begin
      // ebreak wins if both ever showed up together
      if (is_ebreak) begin
        state <= rv_pkg::rc_halted;
      end else if (illegal) begin
        state <= rv_pkg::rc_trapped;
      end
    end
  end

  assign reg_wen = live && reg_wen_raw;
  assign mem_wen = live && mem_wen_raw;
  assign pc_en   = live;
  assign halted  = (state == rv_pkg::rc_halted);
  assign trapped = (state == rv_pkg::rc_trapped);

  a_one_stop_state: assert property (@(posedge clk) disable iff (!rst_n)
    !(halted && trapped));

endmodule

// ==== hw/rv_pc_counter.sv ====
/*
  program counter register
  steps by 4 or by the jal offset when enabled, else holds
*/
`timescale 1ns/10ps

module rv_pc_counter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    pc_en,
  input  logic                    is_jal,
  input  logic [rv_pkg::xlen-1:0] imm,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] pc_plus4
);

  // also the jal link value
  assign pc_plus4 = pc + 64'd4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= rv_pkg::pc_reset;
    end else if (pc_en) begin
      pc <= is_jal ? (pc + imm) : pc_plus4;
    end
  end

  // decoder screens misaligned jal, so every step keeps word alignment
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc_en |=> (pc[1:0] == 2'b00));

endmodule

// ==== hw/rv_alu.sv ====
/*
  64 bit integer alu
  add, sub, signed set-less-than and the three bitwise ops
*/
`timescale 1ns/10ps

module rv_alu (
  input  logic [rv_pkg::xlen-1:0] operand_1,
  input  logic [rv_pkg::xlen-1:0] operand_2,
  input  rv_pkg::alu_op_t         alu_op,
  output logic [rv_pkg::xlen-1:0] alu_result
);

  logic slt_bit;

  // signed compare, result lands in bit 0
  assign slt_bit = $signed(operand_1) < $signed(operand_2);

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add: alu_result = operand_1 + operand_2;
      rv_pkg::alu_sub: alu_result = operand_1 - operand_2;
      rv_pkg::alu_slt: alu_result = {{(rv_pkg::xlen-1){1'b0}}, slt_bit};
      rv_pkg::alu_xor: alu_result = operand_1 ^ operand_2;
      rv_pkg::alu_or:  alu_result = operand_1 | operand_2;
      rv_pkg::alu_and: alu_result = operand_1 & operand_2;
      // two unused codes
      default:         alu_result = '0;
    endcase
  end

endmodule

// ==== hw/rv_regfile.sv ====
/*
  integer register file, 32 x 64 bit
  two combinational reads, one write at the clock edge, x0 reads zero
*/
`timescale 1ns/10ps

module rv_regfile (
  input  logic                            clk,
  input  logic                            reg_wen,
  input  logic [rv_pkg::reg_id_width-1:0] rd,
  input  logic [rv_pkg::reg_id_width-1:0] rs1,
  input  logic [rv_pkg::reg_id_width-1:0] rs2,
  input  logic [rv_pkg::xlen-1:0]         reg_wdata,
  output logic [rv_pkg::xlen-1:0]         rdata_1,
  output logic [rv_pkg::xlen-1:0]         rdata_2
);

  logic [rv_pkg::xlen-1:0] regs [32];

  // writes to x0 are dropped
  always_ff @(posedge clk) begin
    if (reg_wen && rd != '0) begin
      regs[rd] <= reg_wdata;
    end
  end

  // x0 is hardwired on the read side
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

  // a write aimed at x0 must leave x0 reading zero afterwards
  a_x0_stays_zero: assert property (@(posedge clk)
    (reg_wen && rd == '0) |=>
      ((rs1 != '0) || (rdata_1 == '0)) && ((rs2 != '0) || (rdata_2 == '0)));

endmodule

// ==== hw/rv_decoder.sv ====
/*
  instruction decoder: pulls out register fields, builds the sign-extended
  immediate and raises the control strobes, or illegal for anything else
*/
`timescale 1ns/10ps

module rv_decoder (
  input  rv_pkg::inst_word_t                inst,
  output logic [rv_pkg::reg_id_width-1:0]   rd,
  output logic [rv_pkg::reg_id_width-1:0]   rs1,
  output logic [rv_pkg::reg_id_width-1:0]   rs2,
  output logic [rv_pkg::xlen-1:0]           imm,
  output rv_pkg::alu_op_t                   alu_op,
  output logic [1:0]                        store_size,
  output logic                              need_imm,
  output logic                              is_auipc,
  output logic                              is_lui,
  output logic                              is_jal,
  output logic                              reg_wen_raw,
  output logic                              mem_wen_raw,
  output logic                              is_ebreak,
  output logic                              illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // rd, rs1, rs2 sit at the same bits in every format that has them
  assign opcode = inst.r.opcode;
  assign funct3 = inst.r.funct3;
  assign funct7 = inst.r.funct7;
  assign rd     = inst.r.rd;
  assign rs1    = inst.r.rs1;
  assign rs2    = inst.r.rs2;

  always_comb begin
    imm         = '0;
    alu_op      = rv_pkg::alu_add;
    store_size  = 2'd0;
    need_imm    = 1'b0;
    is_auipc    = 1'b0;
    is_lui      = 1'b0;
    is_jal      = 1'b0;
    reg_wen_raw = 1'b0;
    mem_wen_raw = 1'b0;
    is_ebreak   = 1'b0;
    illegal     = 1'b0;
    case (opcode)
      rv_pkg::op_imm: begin
        imm         = {{52{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        need_imm    = 1'b1;
        reg_wen_raw = 1'b1;
        case (funct3)
          rv_pkg::f3_add: alu_op = rv_pkg::alu_add;
          rv_pkg::f3_slt: alu_op = rv_pkg::alu_slt;
          rv_pkg::f3_xor: alu_op = rv_pkg::alu_xor;
          rv_pkg::f3_or:  alu_op = rv_pkg::alu_or;
          rv_pkg::f3_and: alu_op = rv_pkg::alu_and;
          // shifts and sltiu not in the subset
          default:        illegal = 1'b1;
        endcase
      end
      rv_pkg::op: begin
        reg_wen_raw = 1'b1;
        if (funct7 == rv_pkg::f7_alt && funct3 == rv_pkg::f3_add) begin
          alu_op = rv_pkg::alu_sub;
        end else if (funct7 == rv_pkg::f7_base) begin
          case (funct3)
            rv_pkg::f3_add: alu_op = rv_pkg::alu_add;
            rv_pkg::f3_slt: alu_op = rv_pkg::alu_slt;
            rv_pkg::f3_xor: alu_op = rv_pkg::alu_xor;
            rv_pkg::f3_or:  alu_op = rv_pkg::alu_or;
            rv_pkg::f3_and: alu_op = rv_pkg::alu_and;
            default:        illegal = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
      end
      rv_pkg::lui: begin
        imm         = {{32{inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'b0};
        is_lui      = 1'b1;
        reg_wen_raw = 1'b1;
      end
      rv_pkg::auipc: begin
        imm         = {{32{inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'b0};
        is_auipc    = 1'b1;
        need_imm    = 1'b1;
        reg_wen_raw = 1'b1;
      end
      rv_pkg::jal: begin
        imm         = {{43{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
        is_jal      = 1'b1;
        reg_wen_raw = 1'b1;
        // pc is word aligned, so offset bit 1 alone decides the target
        illegal     = inst.j.imm_10_1[0];
      end
      rv_pkg::store: begin
        imm         = {{52{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
        need_imm    = 1'b1;
        mem_wen_raw = 1'b1;
        store_size  = funct3[1:0];
        // funct3 above 3 is not a store width
        illegal     = funct3[2];
      end
      rv_pkg::system: begin
        if (inst == rv_pkg::ebreak_word) begin
          is_ebreak = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
    // an illegal word must not touch any state
    if (illegal) begin
      reg_wen_raw = 1'b0;
      mem_wen_raw = 1'b0;
      is_jal      = 1'b0;
    end
  end

endmodule

// ==== hw/rv_pkg.sv ====
/*
  rv64 core shared definitions: widths, reset pc, opcodes, funct codes,
  alu operation codes and the instruction word seen in its formats
*/
package rv_pkg;

  localparam int xlen         = 64;
  localparam int inst_width   = 32;
  localparam int reg_id_width = 5;

  // first fetch after reset
  localparam logic [xlen-1:0] pc_reset = 64'h0000_0000_8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op     = 7'b0110011;
  localparam logic [6:0] lui    = 7'b0110111;
  localparam logic [6:0] auipc  = 7'b0010111;
  localparam logic [6:0] jal    = 7'b1101111;
  localparam logic [6:0] store  = 7'b0100011;
  localparam logic [6:0] system = 7'b1110011;

  // funct3 for the arithmetic and logic group
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct7 for OP, alt selects sub
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // the only SYSTEM word we accept
  localparam logic [inst_width-1:0] ebreak_word = 32'h0010_0073;

  // run control state codes
  localparam logic [1:0] rc_run     = 2'd0;
  localparam logic [1:0] rc_halted  = 2'd1;
  localparam logic [1:0] rc_trapped = 2'd2;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_slt, alu_xor, alu_or, alu_and
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, five readings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
    j_fmt_t j;
  } inst_word_t;

endpackage
